// ==== design/cmd_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              byte_valid,
    input  wire matrix_pkg::byte_t byte_data,
    output logic                   payload_valid,
    output matrix_pkg::byte_t      payload_data,
    input  wire logic              handler_done,
    output logic                   busy
);
    import matrix_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e      state;
    cmd_opcode_e opcode;

    assign opcode = cmd_opcode_e'(byte_data);

    // **********************************************************************
    // command framing
    // **********************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // anything but READ_ROW is dropped here.
                    if (byte_valid && opcode == CMD_READ_ROW) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (handler_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy = (state == ST_BUSY);

    // payload goes straight through while a command is open.
    assign payload_valid = busy && byte_valid;
    assign payload_data  = byte_data;

    // **********************************************************************
    // checks
    // **********************************************************************

    // the handler only finishes a row inside an open command.
    assert property (@(posedge clk) disable iff (reset)
        handler_done |-> busy)
    else $error("row handler finished outside an open command");

endmodule

`default_nettype wire

// ==== design/cmd_read_row.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_params.svh"

module cmd_read_row (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              enable,
    input  wire matrix_pkg::byte_t data_in,
    fb_write_if.requester          wr,
    output logic                   done
);
    import matrix_pkg::*;

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_PRIME_WRITE,
        ST_ROW_CONTENT,
        ST_DONE
    } state_e;

    localparam column_t    LAST_COLUMN = column_t'(`MATRIX_PIXEL_WIDTH - 1);
    localparam pixel_sel_t LAST_PIXEL  = pixel_sel_t'(`MATRIX_BYTES_PER_PIXEL - 1);

    state_e     state;
    row_t       row;
    column_t    column;
    pixel_sel_t pixel;
    byte_t      data;
    logic       write_enable;
    logic       access_start;
    logic       last_byte;

    // next step lands on column 0, pixel 0.
    assign last_byte = (column == '0) && (pixel == pixel_sel_t'(1));

    // **********************************************************************
    // row load FSM
    // **********************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= ST_ROW_CAPTURE;
            row          <= '0;
            column       <= '0;
            pixel        <= '0;
            write_enable <= 1'b0;
            access_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        row   <= data_in[$bits(row_t)-1:0]; // upper bits ignored.
                        state <= ST_PRIME_WRITE;
                    end
                end
                ST_PRIME_WRITE: begin
                    if (enable) begin
                        // first colour byte goes to the top address.
                        column       <= LAST_COLUMN;
                        pixel        <= LAST_PIXEL;
                        write_enable <= 1'b1;
                        access_start <= ~access_start;
                        state        <= ST_ROW_CONTENT;
                    end
                end
                ST_ROW_CONTENT: begin
                    if (enable) begin
                        access_start <= ~access_start;
                        if (pixel == '0) begin
                            pixel  <= LAST_PIXEL;
                            column <= column - 1'b1;
                        end else begin
                            pixel <= pixel - 1'b1;
                        end
                        if (last_byte) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    done         <= 1'b0;
                    write_enable <= 1'b0;
                    state        <= ST_ROW_CAPTURE;
                end
                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enable && (state == ST_PRIME_WRITE || state == ST_ROW_CONTENT)) begin
            data <= data_in;
        end
    end

    assign wr.row          = row;
    assign wr.column       = column;
    assign wr.pixel        = pixel;
    assign wr.data         = data;
    assign wr.write_enable = write_enable;
    assign wr.access_start = access_start;

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done held longer than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        $changed(access_start) |-> write_enable)
    else $error("write request issued without write enable");

endmodule

`default_nettype wire

// ==== design/fb_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fb_write_if;
    import matrix_pkg::*;

    row_t       row;
    column_t    column;
    pixel_sel_t pixel;
    byte_t      data;
    logic       write_enable;
    logic       access_start;   // toggles once per byte.

    modport requester (
        output row, column, pixel, data,
        output write_enable, access_start
    );

    modport memory (
        input row, column, pixel, data,
        input write_enable, access_start
    );

endinterface

`default_nettype wire

// ==== design/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_params.svh"

module frame_ram (
    input  wire logic                  clk,
    input  wire logic                  reset,
    fb_write_if.memory                 wr,
    input  wire matrix_pkg::row_t      rd_row,
    input  wire matrix_pkg::column_t   rd_column,
    input  wire matrix_pkg::pixel_sel_t rd_pixel,
    output matrix_pkg::byte_t          rd_data
);
    import matrix_pkg::*;

    localparam int ROW_BYTES = `MATRIX_PIXEL_WIDTH * `MATRIX_BYTES_PER_PIXEL;
    localparam int DEPTH     = `MATRIX_PIXEL_HEIGHT * ROW_BYTES;
    localparam int ADDR_W    = $clog2(DEPTH);

    byte_t mem [DEPTH];
    logic  start_q;     // access_start seen last cycle.
    logic  write_req;

    // packed row-major layout, no holes for the unused pixel code.
    function automatic logic [ADDR_W-1:0] linear_addr(
        input row_t       r,
        input column_t    c,
        input pixel_sel_t p
    );
        return ADDR_W'(r) * ADDR_W'(ROW_BYTES)
             + ADDR_W'(c) * ADDR_W'(`MATRIX_BYTES_PER_PIXEL)
             + ADDR_W'(p);
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= wr.access_start;
        end
    end

    assign write_req = (wr.access_start != start_q) && wr.write_enable;

    // **********************************************************************
    // storage and scan-out port
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (write_req) begin
            mem[linear_addr(wr.row, wr.column, wr.pixel)] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[linear_addr(rd_row, rd_column, rd_pixel)]; // one cycle latency.
    end

    assert property (@(posedge clk) disable iff (reset)
        write_req |-> (wr.pixel < `MATRIX_BYTES_PER_PIXEL))
    else $error("write to a colour byte outside the pixel");

endmodule

`default_nettype wire

// ==== design/matrix_cmd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_cmd_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   byte_valid,
    input  wire matrix_pkg::byte_t      byte_data,
    output logic                        busy,
    output logic                        row_done,
    input  wire matrix_pkg::row_t       rd_row,
    input  wire matrix_pkg::column_t    rd_column,
    input  wire matrix_pkg::pixel_sel_t rd_pixel,
    output matrix_pkg::byte_t           rd_data
);
    import matrix_pkg::*;

    logic  payload_valid;
    byte_t payload_data;

    fb_write_if fb_wr ();

    cmd_dispatch u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .payload_valid (payload_valid),
        .payload_data  (payload_data),
        .handler_done  (row_done),
        .busy          (busy)
    );

    cmd_read_row u_read_row (
        .clk     (clk),
        .reset   (reset),
        .enable  (payload_valid),
        .data_in (payload_data),
        .wr      (fb_wr.requester),
        .done    (row_done)         // also closes the command.
    );

    frame_ram u_frame_ram (
        .clk       (clk),
        .reset     (reset),
        .wr        (fb_wr.memory),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .rd_pixel  (rd_pixel),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== design/matrix_params.svh ====
`ifndef MATRIX_PARAMS_SVH
`define MATRIX_PARAMS_SVH

// **********************************************************************
// panel geometry
// **********************************************************************

`define MATRIX_PIXEL_HEIGHT     32      // rows on the panel.
`define MATRIX_PIXEL_WIDTH      64      // columns per row.
`define MATRIX_BYTES_PER_PIXEL  3       // r, g, b.

// **********************************************************************
// host command set
// **********************************************************************

`define MATRIX_OP_READ_ROW      8'h01   // load one row.

`endif

// ==== design/matrix_pkg.sv ====
`default_nettype none

`include "matrix_params.svh"

package matrix_pkg;

    // frame-buffer address fields.
    typedef logic [$clog2(`MATRIX_PIXEL_HEIGHT)-1:0]    row_t;
    typedef logic [$clog2(`MATRIX_PIXEL_WIDTH)-1:0]     column_t;
    typedef logic [$clog2(`MATRIX_BYTES_PER_PIXEL)-1:0] pixel_sel_t;

    typedef logic [7:0] byte_t;

    // opcodes the dispatcher knows about.
    typedef enum logic [7:0] {
        CMD_READ_ROW = `MATRIX_OP_READ_ROW,
        CMD_UNKNOWN  = 8'hFF
    } cmd_opcode_e;

endpackage

`default_nettype wire

// ==== matrix_cmd_top.f ====
+incdir+design
design/matrix_pkg.sv
design/fb_write_if.sv
design/cmd_dispatch.sv
design/cmd_read_row.sv
design/frame_ram.sv
design/matrix_cmd_top.sv
testbench/matrix_cmd_tb.sv

// ==== testbench/matrix_cmd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_params.svh"

module matrix_cmd_tb;
    import matrix_pkg::*;

    localparam int BPP        = `MATRIX_BYTES_PER_PIXEL;
    localparam int ROW_BYTES  = `MATRIX_PIXEL_WIDTH * BPP;
    localparam int MAX_GAP    = 3;
    localparam int ROW_LOADS  = 5;
    localparam int ROW_READS  = 10;
    // every byte followed by the longest gap, plus all read sweeps.
    localparam int MAX_CYCLES = ROW_LOADS * (ROW_BYTES + 4) * (MAX_GAP + 1)
                              + ROW_READS * (ROW_BYTES + 2) + 500;

    logic       clk;
    logic       reset;
    logic       byte_valid;
    byte_t      byte_data;
    logic       busy;
    logic       row_done;
    row_t       rd_row;
    column_t    rd_column;
    pixel_sel_t rd_pixel;
    byte_t      rd_data;

    byte_t  ref_image [`MATRIX_PIXEL_HEIGHT][ROW_BYTES];  // column * BPP + pixel.
    integer seed = 1835;

    matrix_cmd_top dut (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .busy       (busy),
        .row_done   (row_done),
        .rd_row     (rd_row),
        .rd_column  (rd_column),
        .rd_pixel   (rd_pixel),
        .rd_data    (rd_data)
    );

    always #5 clk = ~clk;

    // **********************************************************************
    // helpers
    // **********************************************************************

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic send_byte(input byte_t value);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= value;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            byte_valid <= 1'b0;
        end
    endtask

    task automatic wait_not_busy();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // opcode, row byte, then the whole row; ends with busy low.
    task automatic load_row(input string name, input byte_t row_byte, input int max_gap);
        row_t  row;
        byte_t value;
        int    col;
        int    pix;
        row = row_t'(row_byte % `MATRIX_PIXEL_HEIGHT);
        send_byte(`MATRIX_OP_READ_ROW);
        send_byte(row_byte);
        @(negedge clk);
        check_value({name, " busy after opcode"}, 1, busy);
        for (int i = 0; i < ROW_BYTES; i++) begin
            if (max_gap > 0) begin
                idle_cycles({$random(seed)} % (max_gap + 1));
            end
            value = byte_t'($random(seed));
            col   = `MATRIX_PIXEL_WIDTH - 1 - i / BPP;   // counts down from the top.
            pix   = BPP - 1 - i % BPP;
            ref_image[row][col * BPP + pix] = value;
            send_byte(value);
            @(negedge clk);
            check_value({name, " row_done early"}, 0, row_done);
        end
        idle_cycles(1);
        @(negedge clk);
        check_value({name, " row_done after last byte"}, 1, row_done);
        check_value({name, " busy with row_done"}, 1, busy);
        @(posedge clk);
        @(negedge clk);
        check_value({name, " row_done width"}, 0, row_done);
        check_value({name, " busy after row_done"}, 0, busy);
    endtask

    // address i goes out while the data of address i-1 comes back.
    task automatic check_row(input string name, input row_t row);
        for (int i = 0; i <= ROW_BYTES; i++) begin
            @(posedge clk);
            if (i < ROW_BYTES) begin
                rd_row    <= row;
                rd_column <= column_t'(i / BPP);
                rd_pixel  <= pixel_sel_t'(i % BPP);
            end
            @(negedge clk);
            if (i > 0) begin
                check_value($sformatf("%s row %0d byte %0d", name, row, i - 1),
                            ref_image[row][i - 1], rd_data);
            end
        end
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************

    task automatic test_reset_state();
        @(negedge clk);
        check_value("test_reset_state busy", 0, busy);
        check_value("test_reset_state row_done", 0, row_done);
    endtask

    task automatic test_single_row();
        load_row("test_single_row", 8'd5, 0);
        check_row("test_single_row", 5);
    endtask

    task automatic test_row_with_gaps();
        load_row("test_row_with_gaps", 8'd31, MAX_GAP);
        check_row("test_row_with_gaps", 31);
        check_row("test_row_with_gaps", 5);
    endtask

    task automatic test_unknown_opcode();
        byte_t value;
        send_byte(8'h7E);
        for (int i = 0; i < 8; i++) begin
            value = byte_t'($random(seed));
            if (i == 0) begin
                value = 8'd5;    // would select row 5 if the opcode leaked.
            end else if (value == `MATRIX_OP_READ_ROW) begin
                value = 8'h02;   // keep clear of a real opcode.
            end
            send_byte(value);
            @(negedge clk);
            check_value("test_unknown_opcode busy", 0, busy);
        end
        idle_cycles(2);
        @(negedge clk);
        check_value("test_unknown_opcode busy", 0, busy);
        check_value("test_unknown_opcode row_done", 0, row_done);
        check_row("test_unknown_opcode", 5);
        check_row("test_unknown_opcode", 31);
    endtask

    task automatic test_back_to_back_rows();
        load_row("test_back_to_back_rows", 8'h00, 0);
        wait_not_busy();
        load_row("test_back_to_back_rows", 8'h01, 0);
        wait_not_busy();
        check_row("test_back_to_back_rows", 0);
        check_row("test_back_to_back_rows", 1);
        load_row("test_back_to_back_rows", 8'hE1, 0);   // upper bits dropped.
        wait_not_busy();
        check_row("test_back_to_back_rows", 1);
        check_row("test_back_to_back_rows", 0);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = '0;
        rd_row     = '0;
        rd_column  = '0;
        rd_pixel   = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_single_row();
        test_row_with_gaps();
        test_unknown_opcode();
        test_back_to_back_rows();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 10);
        $display("watchdog: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire
